// ==== cmoc_lb.f ====
verilog/cmoc_lb_pkg.sv
verilog/lb_ctrl.sv
verilog/cavity_sim.sv
verilog/llrf_ctrl.sv
verilog/cmoc_lb_top.sv
tests/cmoc_lb_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the cavity test stand with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module cmoc_lb_tb -f cmoc_lb.f -o cmoc_lb_sim \
	&& ./obj_dir/cmoc_lb_sim > "$log" 2>&1 \
	|| { echo "Build or simulation did not complete"; exit 1; }

cat "$log"

grep -qF "*** TEST FAILED ***" "$log" \
	&& { echo "Simulation reported a failure"; exit 1; } \
	|| { echo "Simulation finished without failures"; exit 0; }

// ==== tests/cmoc_lb_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

// Testbench for the cavity test stand
// Random stimulus from a fixed seed
module cmoc_lb_tb;

	localparam int mode_count = 3;
	localparam int field_w = cmoc_lb_pkg::drive_w + cmoc_lb_pkg::mode_bits;
	// Edges from request sample to ack
	localparam int ack_latency = 2;
	localparam int ack_timeout = 16;

	logic lb_clk;
	logic arst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [cmoc_lb_pkg::adr_w-1:0] wb_adr;
	logic [cmoc_lb_pkg::data_w-1:0] wb_dat_w;
	logic [3:0] wb_sel;
	wire wb_ack;
	wire [cmoc_lb_pkg::data_w-1:0] wb_dat_r;

	integer seed;
	int errors;
	int checks;
	int tests_run;
	int test_start_errors;
	bit timed_out;
	string current_test;

	// Controller register offsets and their widths
	logic [cmoc_lb_pkg::lb_aw-1:0] ctl_regs [5];
	int ctl_widths [5];

	cmoc_lb_top #(
		.mode_count(mode_count)
	) cmoc_lb_top_inst (
		.lb_clk(lb_clk), .arst_n(arst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel),
		.wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
	);

	// 100 ns clock
	always #50 lb_clk = ~lb_clk;

	// Region bit 16 picks the half
	function automatic logic [cmoc_lb_pkg::adr_w-1:0] ctl_adr(input logic [15:0] off);
		return {1'b0, off};
	endfunction

	function automatic logic [cmoc_lb_pkg::adr_w-1:0] sim_adr(input logic [15:0] off);
		return {1'b1, off};
	endfunction

	function automatic logic [31:0] width_mask(input int n);
		return (32'h1 << n) - 32'h1;
	endfunction

	task automatic start_test(input string name);
		current_test = name;
		test_start_errors = errors;
		tests_run++;
	endtask

	task automatic end_test();
		$display("%s: done, %0d errors", current_test, errors - test_start_errors);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h",
				current_test, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_near(input string name, input int exp, input int act, input int tol);
		int diff;
		checks++;
		diff = (act > exp) ? act - exp : exp - act;
		assert (diff <= tol) else begin
			$display("[FAIL] %s %s: expected %0d within %0d, actual %0d",
				current_test, name, exp, tol, act);
			errors++;
		end
	endtask

	// Ack must stay low while no request is on the bus
	task automatic idle_cycles(input int n);
		for (int k = 0; k < n; k++) begin
			@(negedge lb_clk);
			assert (!wb_ack) else begin
				$display("%s: ack seen with no request on the bus", current_test);
				errors++;
			end
		end
	endtask

	// One access starts and ends on a falling edge
	task automatic bus_access(input logic we, input logic [cmoc_lb_pkg::adr_w-1:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		rdata = '0;
		if (timed_out) return;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		wb_sel = 4'hf;
		waited = 0;
		while (!wb_ack && waited < ack_timeout) begin
			@(negedge lb_clk);
			waited++;
		end
		if (!wb_ack) begin
			$display("%s: no ack within %0d cycles of a request", current_test, ack_timeout);
			errors++;
			timed_out = 1'b1;
		end else begin
			// First falling edge comes half a cycle after the sampling edge
			check_value("ack latency", ack_latency, waited - 1);
			rdata = wb_dat_r;
		end
		// Strobe dropped for one cycle after ack
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(negedge lb_clk);
		assert (!wb_ack) else begin
			$display("%s: ack held for more than one cycle", current_test);
			errors++;
		end
	endtask

	task automatic wb_write(input logic [cmoc_lb_pkg::adr_w-1:0] adr, input logic [31:0] data);
		logic [31:0] discard;
		bus_access(1'b1, adr, data, discard);
	endtask

	task automatic wb_read(input logic [cmoc_lb_pkg::adr_w-1:0] adr, output logic [31:0] data);
		bus_access(1'b0, adr, '0, data);
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] f1;
		logic [31:0] ctl_w [5];
		logic [31:0] run_w;
		logic [31:0] sh_w [mode_count];
		logic [15:0] off;
		int sh [mode_count];
		int ol;
		int sp;
		int kp;
		int ki;
		int tol;
		int bound;
		seed = 63905;
		errors = 0;
		checks = 0;
		tests_run = 0;
		timed_out = 1'b0;
		current_test = "reset";
		ctl_regs = '{cmoc_lb_pkg::reg_setpoint, cmoc_lb_pkg::reg_kp, cmoc_lb_pkg::reg_ki,
			cmoc_lb_pkg::reg_enable, cmoc_lb_pkg::reg_openloop};
		ctl_widths = '{field_w, cmoc_lb_pkg::gain_w, cmoc_lb_pkg::gain_w, 1,
			cmoc_lb_pkg::drive_w};
		lb_clk = 1'b0;
		arst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = 4'h0;
		// Reset held for 8 cycles and released on a falling edge
		repeat (8) @(negedge lb_clk);
		arst_n = 1'b1;
		idle_cycles(2);

		start_test("register_readback");
		for (int r = 0; r < 5; r++) begin
			ctl_w[r] = $random(seed);
			wb_write(ctl_adr(ctl_regs[r]), ctl_w[r]);
		end
		run_w = $random(seed);
		wb_write(sim_adr(cmoc_lb_pkg::reg_run), run_w);
		for (int i = 0; i < mode_count; i++) begin
			sh_w[i] = $random(seed);
			wb_write(sim_adr(cmoc_lb_pkg::reg_shift_base + 16'(i)), sh_w[i]);
		end
		for (int r = 0; r < 5; r++) begin
			wb_read(ctl_adr(ctl_regs[r]), rd);
			check_value("controller register", ctl_w[r] & width_mask(ctl_widths[r]),
				rd & width_mask(ctl_widths[r]));
		end
		wb_read(sim_adr(cmoc_lb_pkg::reg_run), rd);
		check_value("run", run_w & 32'h1, rd & 32'h1);
		for (int i = 0; i < mode_count; i++) begin
			wb_read(sim_adr(cmoc_lb_pkg::reg_shift_base + 16'(i)), rd);
			check_value("mode shift", sh_w[i] & width_mask(cmoc_lb_pkg::shift_w),
				rd & width_mask(cmoc_lb_pkg::shift_w));
		end
		// Absent modes and unmapped offsets
		for (int i = mode_count; i < 16; i++) begin
			wb_read(sim_adr(cmoc_lb_pkg::reg_shift_base + 16'(i)), rd);
			check_value("absent mode shift", 32'h0, rd);
			wb_read(sim_adr(cmoc_lb_pkg::reg_state_base + 16'(i)), rd);
			check_value("absent mode state", 32'h0, rd);
		end
		for (int k = 0; k < 4; k++) begin
			off = 16'h0007 + 16'({$random(seed)} % 32'hfff8);
			wb_read(ctl_adr(off), rd);
			check_value("unmapped controller offset", 32'h0, rd);
			off = 16'h0040 + 16'({$random(seed)} % 32'hffc0);
			wb_read(sim_adr(off), rd);
			check_value("unmapped simulator offset", 32'h0, rd);
		end
		end_test();

		// Random accesses with gaps of zero to two cycles
		start_test("ack_timing");
		for (int k = 0; k < 40; k++) begin
			off = 16'h0100 + 16'({$random(seed)} % 32'hff00);
			if ($random(seed) & 1) begin
				wb_write({1'($random(seed)), off}, $random(seed));
			end else begin
				wb_read({1'($random(seed)), off}, rd);
				check_value("unmapped read", 32'h0, rd);
			end
			idle_cycles({$random(seed)} % 3);
		end
		end_test();

		start_test("clear_and_hold");
		wb_write(ctl_adr(cmoc_lb_pkg::reg_enable), 32'h0);
		// Slow modes stopped partway towards a known drive
		wb_write(ctl_adr(cmoc_lb_pkg::reg_openloop), 32'h1000);
		for (int i = 0; i < mode_count; i++) begin
			wb_write(sim_adr(cmoc_lb_pkg::reg_shift_base + 16'(i)), 32'h4);
		end
		wb_write(sim_adr(cmoc_lb_pkg::reg_run), 32'h1);
		idle_cycles(8);
		wb_write(sim_adr(cmoc_lb_pkg::reg_run), 32'h0);
		wb_read(sim_adr(cmoc_lb_pkg::reg_field), f1);
		idle_cycles(1 + {$random(seed)} % 64);
		wb_read(sim_adr(cmoc_lb_pkg::reg_field), rd);
		check_value("held field", f1, rd);
		wb_write(sim_adr(cmoc_lb_pkg::reg_clear), 32'h1);
		for (int i = 0; i < mode_count; i++) begin
			wb_read(sim_adr(cmoc_lb_pkg::reg_state_base + 16'(i)), rd);
			check_value("cleared state", 32'h0, rd);
		end
		wb_read(sim_adr(cmoc_lb_pkg::reg_field), rd);
		check_value("cleared field", 32'h0, rd);
		end_test();

		start_test("openloop_settling");
		ol = $random(seed) % (1 << 14);
		wb_write(ctl_adr(cmoc_lb_pkg::reg_openloop), ol);
		for (int i = 0; i < mode_count; i++) begin
			sh[i] = 1 + {$random(seed)} % 4;
			wb_write(sim_adr(cmoc_lb_pkg::reg_shift_base + 16'(i)), sh[i]);
		end
		wb_write(sim_adr(cmoc_lb_pkg::reg_run), 32'h1);
		idle_cycles(2000);
		// Each mode rests less than one shift step from the drive
		bound = 0;
		for (int i = 0; i < mode_count; i++) begin
			wb_read(sim_adr(cmoc_lb_pkg::reg_state_base + 16'(i)), rd);
			check_near("mode state", ol, $signed(rd), 1 << sh[i]);
			bound += 1 << sh[i];
		end
		wb_read(sim_adr(cmoc_lb_pkg::reg_field), rd);
		check_near("field", mode_count * ol, $signed(rd), bound);
		wb_read(ctl_adr(cmoc_lb_pkg::reg_drive), rd);
		check_value("drive", ol, rd);
		end_test();

		start_test("closed_loop_tracking");
		sp = $random(seed) % (mode_count << 12);
		kp = 16 + {$random(seed)} % 49;
		ki = 1 + {$random(seed)} % 8;
		wb_write(ctl_adr(cmoc_lb_pkg::reg_setpoint), sp);
		wb_write(ctl_adr(cmoc_lb_pkg::reg_kp), kp);
		wb_write(ctl_adr(cmoc_lb_pkg::reg_ki), ki);
		for (int i = 0; i < mode_count; i++) begin
			wb_write(sim_adr(cmoc_lb_pkg::reg_shift_base + 16'(i)), 32'h2);
		end
		wb_write(sim_adr(cmoc_lb_pkg::reg_clear), 32'h1);
		wb_write(ctl_adr(cmoc_lb_pkg::reg_enable), 32'h1);
		idle_cycles(20000);
		// Integrator step rounds to zero once ki times error is below 2^gain_shift
		tol = 4 * mode_count + ((1 << cmoc_lb_pkg::gain_shift) + ki - 1) / ki;
		wb_read(sim_adr(cmoc_lb_pkg::reg_field), rd);
		check_near("field", sp, $signed(rd), tol);
		wb_read(ctl_adr(cmoc_lb_pkg::reg_error), rd);
		check_near("error", 0, $signed(rd), tol);
		end_test();

		start_test("disable_integrator");
		wb_write(ctl_adr(cmoc_lb_pkg::reg_enable), 32'h0);
		wb_read(ctl_adr(cmoc_lb_pkg::reg_drive), rd);
		check_value("drive", ol, rd);
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/cmoc_lb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// Cavity test stand behind a Wishbone host bus
// Simulator in the upper half of the word space, controller in the lower half
module cmoc_lb_top #(
	parameter int mode_count = 3
) (
	input wire lb_clk,
	input wire arst_n,
	// Wishbone classic slave
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [cmoc_lb_pkg::adr_w-1:0] wb_adr,
	input wire [cmoc_lb_pkg::data_w-1:0] wb_dat_w,
	input wire [3:0] wb_sel,
	output logic wb_ack,
	output logic [cmoc_lb_pkg::data_w-1:0] wb_dat_r
);

	localparam int field_w = cmoc_lb_pkg::drive_w + cmoc_lb_pkg::mode_bits;

	// Local bus shared by both datapaths
	wire [cmoc_lb_pkg::lb_aw-1:0] lb_addr;
	wire [cmoc_lb_pkg::data_w-1:0] lb_wdata;
	wire lb_write;
	wire sim_strobe;
	wire ctl_strobe;
	wire [cmoc_lb_pkg::data_w-1:0] sim_rdata;
	wire [cmoc_lb_pkg::data_w-1:0] ctl_rdata;

	// Loop between controller and cavity
	wire signed [cmoc_lb_pkg::drive_w-1:0] drive;
	wire signed [field_w-1:0] field;

	lb_ctrl lb_ctrl_inst (
		.lb_clk(lb_clk), .arst_n(arst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel),
		.wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
		.lb_addr(lb_addr), .lb_wdata(lb_wdata), .lb_write(lb_write),
		.sim_strobe(sim_strobe), .ctl_strobe(ctl_strobe),
		.sim_rdata(sim_rdata), .ctl_rdata(ctl_rdata)
	);

	// Upper half
	cavity_sim #(
		.mode_count(mode_count)
	) cavity_sim_inst (
		.lb_clk(lb_clk), .arst_n(arst_n),
		.lb_addr(lb_addr), .lb_wdata(lb_wdata), .lb_write(lb_write),
		.lb_strobe(sim_strobe), .lb_rdata(sim_rdata),
		.drive(drive), .field(field)
	);

	// Lower half
	llrf_ctrl llrf_ctrl_inst (
		.lb_clk(lb_clk), .arst_n(arst_n),
		.lb_addr(lb_addr), .lb_wdata(lb_wdata), .lb_write(lb_write),
		.lb_strobe(ctl_strobe), .lb_rdata(ctl_rdata),
		.field(field), .drive(drive)
	);

endmodule

`default_nettype wire

// ==== verilog/llrf_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

// Proportional-integral feedback from cavity field to cavity drive
// Open-loop drive takes over while the loop is disabled
module llrf_ctrl #(
	// Same field width as the simulator derives
	localparam int field_w = cmoc_lb_pkg::drive_w + cmoc_lb_pkg::mode_bits
) (
	input wire lb_clk,
	input wire arst_n,
	// Local bus, controller region
	input wire [cmoc_lb_pkg::lb_aw-1:0] lb_addr,
	input wire [cmoc_lb_pkg::data_w-1:0] lb_wdata,
	input wire lb_write,
	input wire lb_strobe,
	output logic [cmoc_lb_pkg::data_w-1:0] lb_rdata,
	// Cavity field in, drive out
	input wire signed [field_w-1:0] field,
	output logic signed [cmoc_lb_pkg::drive_w-1:0] drive
);

	localparam int dw = cmoc_lb_pkg::data_w;
	localparam int vw = cmoc_lb_pkg::drive_w;
	localparam int iw = cmoc_lb_pkg::integ_w;
	localparam int gw = cmoc_lb_pkg::gain_w;
	// Error carries one bit more than the field
	localparam int ew = field_w + 1;
	// Product of error and a zero extended gain
	localparam int pw = ew + gw + 1;

	// Register file
	logic signed [field_w-1:0] setpoint;
	logic [gw-1:0] kp;
	logic [gw-1:0] ki;
	logic enable;
	logic signed [vw-1:0] openloop;

	// Loop state
	logic signed [ew-1:0] error;
	logic signed [iw-1:0] integ;

	logic signed [pw-1:0] p_prod;
	logic signed [pw-1:0] i_prod;
	logic signed [pw-1:0] integ_sum;
	logic signed [pw-1:0] drive_sum;
	logic signed [iw-1:0] integ_next;
	logic signed [vw-1:0] drive_next;
	logic wr_en;
	logic [dw-1:0] rd_word;

	assign wr_en = lb_strobe && lb_write;

	// Gains are unsigned, so extend them with a zero sign bit
	always_comb begin
		p_prod = error * $signed({1'b0, kp});
		i_prod = error * $signed({1'b0, ki});
		integ_sum = integ + (i_prod >>> cmoc_lb_pkg::gain_shift);
		drive_sum = (p_prod >>> cmoc_lb_pkg::gain_shift) + integ;
	end

	// Saturate integrator and drive
	always_comb begin
		if (integ_sum > cmoc_lb_pkg::integ_max) begin
			integ_next = cmoc_lb_pkg::integ_max;
		end else if (integ_sum < cmoc_lb_pkg::integ_min) begin
			integ_next = cmoc_lb_pkg::integ_min;
		end else begin
			integ_next = integ_sum[iw-1:0];
		end
		if (drive_sum > cmoc_lb_pkg::drive_max) begin
			drive_next = cmoc_lb_pkg::drive_max;
		end else if (drive_sum < cmoc_lb_pkg::drive_min) begin
			drive_next = cmoc_lb_pkg::drive_min;
		end else begin
			drive_next = drive_sum[vw-1:0];
		end
	end

	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n) begin
			setpoint <= '0;
			kp <= '0;
			ki <= '0;
			enable <= 1'b0;
			openloop <= '0;
			error <= '0;
			integ <= '0;
			drive <= '0;
		end else begin
			if (wr_en) begin
				case (lb_addr)
					cmoc_lb_pkg::reg_setpoint: setpoint <= lb_wdata[field_w-1:0];
					cmoc_lb_pkg::reg_kp: kp <= lb_wdata[gw-1:0];
					cmoc_lb_pkg::reg_ki: ki <= lb_wdata[gw-1:0];
					cmoc_lb_pkg::reg_enable: enable <= lb_wdata[0];
					cmoc_lb_pkg::reg_openloop: openloop <= lb_wdata[vw-1:0];
					default: ;
				endcase
			end
			error <= setpoint - field;
			if (enable) begin
				integ <= integ_next;
				drive <= drive_next;
			end else begin
				// Integrator held at zero while open loop
				integ <= '0;
				drive <= openloop;
			end
		end
	end

	// Signed registers read back sign extended
	always_comb begin
		case (lb_addr)
			cmoc_lb_pkg::reg_setpoint: rd_word = {{(dw-field_w){setpoint[field_w-1]}}, setpoint};
			cmoc_lb_pkg::reg_kp: rd_word = {{(dw-gw){1'b0}}, kp};
			cmoc_lb_pkg::reg_ki: rd_word = {{(dw-gw){1'b0}}, ki};
			cmoc_lb_pkg::reg_enable: rd_word = {{(dw-1){1'b0}}, enable};
			cmoc_lb_pkg::reg_openloop: rd_word = {{(dw-vw){openloop[vw-1]}}, openloop};
			cmoc_lb_pkg::reg_error: rd_word = {{(dw-ew){error[ew-1]}}, error};
			cmoc_lb_pkg::reg_drive: rd_word = {{(dw-vw){drive[vw-1]}}, drive};
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge lb_clk) begin
		if (lb_strobe) begin
			lb_rdata <= rd_word;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cavity_sim.sv ====
`timescale 1ns/10ps
`default_nettype none

// Multi-mode cavity model
// Each mode is a first-order low pass towards the drive
module cavity_sim #(
	parameter int mode_count = 3,
	// Room for the sum of up to eight modes
	localparam int field_w = cmoc_lb_pkg::drive_w + cmoc_lb_pkg::mode_bits
) (
	input wire lb_clk,
	input wire arst_n,
	// Local bus, simulator region
	input wire [cmoc_lb_pkg::lb_aw-1:0] lb_addr,
	input wire [cmoc_lb_pkg::data_w-1:0] lb_wdata,
	input wire lb_write,
	input wire lb_strobe,
	output logic [cmoc_lb_pkg::data_w-1:0] lb_rdata,
	// Cavity drive in, summed field out
	input wire signed [cmoc_lb_pkg::drive_w-1:0] drive,
	output logic signed [field_w-1:0] field
);

	localparam int dw = cmoc_lb_pkg::data_w;
	localparam int vw = cmoc_lb_pkg::drive_w;
	localparam int sw = cmoc_lb_pkg::shift_w;

	logic run;
	logic signed [vw-1:0] state [mode_count];
	logic [sw-1:0] shift [mode_count];
	// One guard bit for the difference drive minus state
	logic signed [vw:0] step [mode_count];
	logic signed [vw:0] nxt [mode_count];
	logic signed [field_w-1:0] sum;
	logic wr_en;
	logic clear;
	logic shift_hit;
	logic state_hit;
	logic [3:0] mode_idx;
	logic [dw-1:0] rd_word;

	assign wr_en = lb_strobe && lb_write;
	assign clear = wr_en && (lb_addr == cmoc_lb_pkg::reg_clear);

	// Per mode blocks decode on the upper address bits
	assign mode_idx = lb_addr[3:0];
	assign shift_hit = (lb_addr >> 4) == (cmoc_lb_pkg::reg_shift_base >> 4);
	assign state_hit = (lb_addr >> 4) == (cmoc_lb_pkg::reg_state_base >> 4);

	// First-order step, state moves by (drive - state) >>> shift
	always_comb begin
		for (int i = 0; i < mode_count; i++) begin
			step[i] = (drive - state[i]) >>> shift[i];
			nxt[i] = state[i] + step[i];
		end
	end

	// Field is the plain sum of all mode states
	always_comb begin
		sum = '0;
		for (int i = 0; i < mode_count; i++) begin
			sum = sum + state[i];
		end
	end

	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n) begin
			run <= 1'b0;
			field <= '0;
			for (int i = 0; i < mode_count; i++) begin
				state[i] <= '0;
				shift[i] <= '0;
			end
		end else begin
			// Registered sum, one cycle behind the states
			field <= sum;
			if (wr_en && (lb_addr == cmoc_lb_pkg::reg_run)) begin
				run <= lb_wdata[0];
			end
			for (int i = 0; i < mode_count; i++) begin
				if (wr_en && shift_hit && (mode_idx == i)) begin
					shift[i] <= lb_wdata[sw-1:0];
				end
				// Clear wins over the running update
				if (clear) begin
					state[i] <= '0;
				end else if (run) begin
					// Result stays between old state and drive
					state[i] <= nxt[i][vw-1:0];
				end
			end
		end
	end

	// Read decode, unmapped offsets and absent modes give zero
	always_comb begin
		rd_word = '0;
		if (lb_addr == cmoc_lb_pkg::reg_run) begin
			rd_word[0] = run;
		end
		if (lb_addr == cmoc_lb_pkg::reg_field) begin
			rd_word = {{(dw-field_w){field[field_w-1]}}, field};
		end
		for (int i = 0; i < mode_count; i++) begin
			if (shift_hit && (mode_idx == i)) begin
				rd_word[sw-1:0] = shift[i];
			end
			// States read back sign extended
			if (state_hit && (mode_idx == i)) begin
				rd_word = {{(dw-vw){state[i][vw-1]}}, state[i]};
			end
		end
	end

	// Read word captured on every strobe
	always_ff @(posedge lb_clk) begin
		if (lb_strobe) begin
			lb_rdata <= rd_word;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/lb_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

// Wishbone classic slave to local bus bridge
// Fixed latency with ack two cycles after the request is taken
module lb_ctrl (
	input wire lb_clk,
	input wire arst_n,
	// Wishbone classic slave
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [cmoc_lb_pkg::adr_w-1:0] wb_adr,
	input wire [cmoc_lb_pkg::data_w-1:0] wb_dat_w,
	input wire [3:0] wb_sel,
	output logic wb_ack,
	output logic [cmoc_lb_pkg::data_w-1:0] wb_dat_r,
	// Local bus towards both datapaths
	output logic [cmoc_lb_pkg::lb_aw-1:0] lb_addr,
	output logic [cmoc_lb_pkg::data_w-1:0] lb_wdata,
	output logic lb_write,
	output logic sim_strobe,
	output logic ctl_strobe,
	// Registered read words valid the cycle after the strobe
	input wire [cmoc_lb_pkg::data_w-1:0] sim_rdata,
	input wire [cmoc_lb_pkg::data_w-1:0] ctl_rdata
);

	// Access sequence
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_strobe = 2'd1;
	localparam logic [1:0] st_wait = 2'd2;
	localparam logic [1:0] st_ack = 2'd3;

	logic [1:0] state;
	// High selects the simulator
	logic region;
	logic write_q;
	logic take;

	// A request is only taken from idle
	// so the ack cycle never starts a new access
	assign take = (state == st_idle) && wb_cyc && wb_stb;

	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			region <= 1'b0;
			write_q <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (take) begin
						state <= st_strobe;
						// Address bit 16 splits the word space in two
						region <= wb_adr[cmoc_lb_pkg::lb_aw];
						// Writes always update the whole register
						write_q <= wb_we;
					end
				end
				// The datapath samples the bus in the strobe cycle
				st_strobe: state <= st_wait;
				// Datapath read word is now registered
				st_wait: state <= st_ack;
				default: state <= st_idle;
			endcase
		end
	end

	// Address and write data held for the whole access
	always_ff @(posedge lb_clk) begin
		if (take) begin
			lb_addr <= wb_adr[cmoc_lb_pkg::lb_aw-1:0];
			lb_wdata <= wb_dat_w;
		end
	end

	assign lb_write = write_q;

	// One strobe cycle routed by the latched region
	assign sim_strobe = (state == st_strobe) && region;
	assign ctl_strobe = (state == st_strobe) && !region;

	// Single cycle ack
	assign wb_ack = (state == st_ack);

	// Read mux follows the region of the access being acknowledged
	assign wb_dat_r = region ? sim_rdata : ctl_rdata;

endmodule

`default_nettype wire

// ==== verilog/cmoc_lb_pkg.sv ====
`default_nettype none

// Shared widths, register map and constants for the cavity test stand
package cmoc_lb_pkg;

	// Host and local bus widths
	localparam int data_w = 32;
	localparam int adr_w = 17;
	// Address below the region bit
	localparam int lb_aw = 16;

	// Datapath widths
	localparam int drive_w = 16;
	localparam int integ_w = 24;
	localparam int gain_w = 8;
	localparam int shift_w = 4;
	// Extra field bits so that the sum of up to eight modes cannot overflow
	localparam int mode_bits = 3;
	// Scaling after each gain product
	localparam int gain_shift = 8;

	// Saturation limits
	localparam logic signed [drive_w-1:0] drive_max = {1'b0, {(drive_w-1){1'b1}}};
	localparam logic signed [drive_w-1:0] drive_min = {1'b1, {(drive_w-1){1'b0}}};
	localparam logic signed [integ_w-1:0] integ_max = {1'b0, {(integ_w-1){1'b1}}};
	localparam logic signed [integ_w-1:0] integ_min = {1'b1, {(integ_w-1){1'b0}}};

	// Controller region, lower half of the word space
	localparam logic [lb_aw-1:0] reg_setpoint = 16'h0000;
	localparam logic [lb_aw-1:0] reg_kp = 16'h0001;
	localparam logic [lb_aw-1:0] reg_ki = 16'h0002;
	localparam logic [lb_aw-1:0] reg_enable = 16'h0003;
	localparam logic [lb_aw-1:0] reg_openloop = 16'h0004;
	localparam logic [lb_aw-1:0] reg_error = 16'h0005;
	localparam logic [lb_aw-1:0] reg_drive = 16'h0006;

	// Simulator region, upper half
	localparam logic [lb_aw-1:0] reg_run = 16'h0000;
	localparam logic [lb_aw-1:0] reg_clear = 16'h0001;
	// Per mode blocks, mode index in the low nibble
	localparam logic [lb_aw-1:0] reg_shift_base = 16'h0010;
	localparam logic [lb_aw-1:0] reg_state_base = 16'h0020;
	localparam logic [lb_aw-1:0] reg_field = 16'h0030;

endpackage

`default_nettype wire
